// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_aud_top
FILELIST  ?= aud_top.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

SIM_BIN = $(BUILD_DIR)/V$(TOP)
SOURCES = $(wildcard design/*.sv sim/*.sv)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	-./$(SIM_BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "test failed" $(LOG); then echo "simulation reported failure"; exit 1; fi
	@grep -q "test passed" $(LOG) || { echo "simulation did not complete"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== aud_top.f ====
design/aud_pkg.sv
design/aud_ctrl.sv
design/aud_recorder.sv
design/aud_dsp.sv
design/aud_player.sv
design/sram_arbiter.sv
design/aud_top.sv
sim/tb_clkgen.sv
sim/tb_aud_top.sv

// ==== design/aud_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module aud_ctrl (
	input  wire                i_AUD_BCLK,
	input  wire                i_rst_n,
	input  wire                i_key_rec,
	input  wire                i_key_play,
	input  wire                i_key_stop,
	input  wire                i_rec_done,
	input  wire                i_play_done,
	output aud_pkg::aud_mode_e o_mode
);
	import aud_pkg::*;

	// bit 0 record, bit 1 play, bit 2 stop
	logic [2:0] key_q;
	logic [2:0] key_d;
	logic [2:0] press;
	aud_mode_e  mode_n;

	// keys are active low, a press is the falling edge
	assign press = key_d & ~key_q;

	always_ff @(posedge i_AUD_BCLK or posedge i_rst_n) begin
		if (i_rst_n) begin
			key_q  <= '1;
			key_d  <= '1;
			o_mode <= MODE_STOP;
		end else begin
			key_q  <= {i_key_stop, i_key_play, i_key_rec};
			key_d  <= key_q;
			o_mode <= mode_n;
		end
	end

	always_comb begin
		mode_n = o_mode;
		case (o_mode)
			MODE_STOP: begin
				if (press[0])
					mode_n = MODE_RECD;
				else if (press[1])
					mode_n = MODE_PLAY;
			end
			MODE_RECD: begin
				if (i_rec_done)
					mode_n = MODE_STOP;
				else if (press[0])
					mode_n = MODE_RECD_PAUSE;
			end
			MODE_RECD_PAUSE: begin
				if (press[0])
					mode_n = MODE_RECD;
				else if (press[2])
					mode_n = MODE_STOP;
			end
			MODE_PLAY: begin
				if (i_play_done)
					mode_n = MODE_STOP;
				else if (press[1])
					mode_n = MODE_PLAY_PAUSE;
			end
			MODE_PLAY_PAUSE: begin
				if (press[1])
					mode_n = MODE_PLAY;
				else if (press[2])
					mode_n = MODE_STOP;
			end
			default: mode_n = MODE_STOP;
		endcase
	end

	a_mode_legal: assert property (@(posedge i_AUD_BCLK) disable iff (i_rst_n)
		o_mode inside {MODE_STOP, MODE_RECD, MODE_RECD_PAUSE, MODE_PLAY, MODE_PLAY_PAUSE});

endmodule

`default_nettype wire

// ==== design/aud_dsp.sv ====
`timescale 1ns/1ps
`default_nettype none

module aud_dsp (
	input  wire                          i_AUD_BCLK,
	input  wire                          i_rst_n,
	input  wire aud_pkg::aud_mode_e      i_mode,
	input  wire aud_pkg::speed_cfg_t     i_speed,
	input  wire [aud_pkg::ADDR_W:0]      i_rec_len,
	input  wire                          i_daclrck,
	input  wire                          i_gnt,
	input  wire [aud_pkg::SAMPLE_W-1:0]  i_rdata,
	output logic                         o_req,
	output aud_pkg::sram_req_t           o_sram,
	output logic [aud_pkg::SAMPLE_W-1:0] o_sample,
	output logic                         o_valid,
	output logic                         o_done
);
	import aud_pkg::*;

	aud_mode_e       mode_d;
	logic            lrck_d;
	logic            lrck_rise;
	logic            restart;
	logic            last_read;
	logic [ADDR_W:0] play_addr;
	logic [ADDR_W:0] next_addr;
	logic [2:0]      rep_cnt;

	assign lrck_rise = ~lrck_d & i_daclrck;
	assign restart   = (i_mode == MODE_PLAY) && (mode_d == MODE_STOP);

	// address after the current read
	always_comb begin
		next_addr = play_addr + 1'b1;
		last_read = 1'b1;
		if (i_speed.fast) begin
			next_addr = play_addr + i_speed.rate + 1'b1;
		end else if (i_speed.slow && rep_cnt != i_speed.rate) begin
			next_addr = play_addr;
			last_read = 1'b0;
		end
	end

	always_ff @(posedge i_AUD_BCLK or posedge i_rst_n) begin
		if (i_rst_n) begin
			mode_d    <= MODE_STOP;
			lrck_d    <= 1'b0;
			play_addr <= '0;
			rep_cnt   <= '0;
			o_req     <= 1'b0;
			o_valid   <= 1'b0;
			o_done    <= 1'b0;
		end else begin
			mode_d <= i_mode;
			lrck_d <= i_daclrck;
			o_done <= 1'b0;
			if (restart) begin
				play_addr <= '0;
				rep_cnt   <= '0;
				o_valid   <= 1'b0;
			end else if (o_req && i_gnt) begin
				o_req     <= 1'b0;
				o_valid   <= 1'b1;
				play_addr <= next_addr;
				rep_cnt   <= last_read ? 3'd0 : rep_cnt + 1'b1;
				if (next_addr >= i_rec_len)
					o_done <= 1'b1;
			end else if (lrck_rise) begin
				// a frame without a fresh read plays silence
				o_valid <= 1'b0;
				if (i_mode == MODE_PLAY) begin
					if (play_addr < i_rec_len)
						o_req <= 1'b1;
					else
						o_done <= 1'b1;
				end
			end
		end
	end

	always_ff @(posedge i_AUD_BCLK) begin
		if (o_req && i_gnt)
			o_sample <= i_rdata;
	end

	always_comb begin
		o_sram.addr  = play_addr[ADDR_W-1:0];
		o_sram.we    = 1'b0;
		o_sram.wdata = '0;
	end

	a_read_only: assert property (@(posedge i_AUD_BCLK) disable iff (i_rst_n)
		!o_sram.we);

endmodule

`default_nettype wire

// ==== design/aud_pkg.sv ====
`default_nettype none

package aud_pkg;

	// audio word and SRAM sizes
	localparam int SAMPLE_W = 16;
	localparam int ADDR_W   = 10;

	// recording stops once this address has been written
	localparam logic [ADDR_W-1:0] MEM_LAST = '1;

	typedef enum logic [2:0] {
		MODE_STOP       = 3'd0,
		MODE_RECD       = 3'd1,
		MODE_RECD_PAUSE = 3'd2,
		MODE_PLAY       = 3'd3,
		MODE_PLAY_PAUSE = 3'd4
	} aud_mode_e;

	// fast wins over slow, both clear is normal speed
	typedef struct packed {
		logic       fast;
		logic       slow;
		logic [2:0] rate;
	} speed_cfg_t;

	// one access on the shared SRAM port
	typedef struct packed {
		logic [ADDR_W-1:0]   addr;
		logic                we;
		logic [SAMPLE_W-1:0] wdata;
	} sram_req_t;

endpackage

`default_nettype wire

// ==== design/aud_player.sv ====
`timescale 1ns/1ps
`default_nettype none

module aud_player (
	input  wire                         i_AUD_BCLK,
	input  wire                         i_rst_n,
	input  wire                         i_daclrck,
	input  wire [aud_pkg::SAMPLE_W-1:0] i_sample,
	input  wire                         i_valid,
	output logic                        o_dacdat
);
	import aud_pkg::*;

	logic                      lrck_d;
	logic                      lrck_fall;
	logic [SAMPLE_W-1:0]       shift_r;
	logic [$clog2(SAMPLE_W):0] bits_left;

	// left half starts when LRCK goes low
	assign lrck_fall = lrck_d & ~i_daclrck;

	always_ff @(posedge i_AUD_BCLK or posedge i_rst_n) begin
		if (i_rst_n) begin
			lrck_d    <= 1'b0;
			bits_left <= '0;
			o_dacdat  <= 1'b0;
		end else begin
			lrck_d <= i_daclrck;
			if (lrck_fall) begin
				bits_left <= ($clog2(SAMPLE_W) + 1)'(SAMPLE_W);
			end else if (bits_left != '0) begin
				bits_left <= bits_left - 1'b1;
				o_dacdat  <= shift_r[SAMPLE_W-1];
			end else begin
				o_dacdat <= 1'b0;
			end
		end
	end

	always_ff @(posedge i_AUD_BCLK) begin
		if (lrck_fall)
			shift_r <= i_valid ? i_sample : '0;
		else if (bits_left != '0)
			shift_r <= {shift_r[SAMPLE_W-2:0], 1'b0};
	end

endmodule

`default_nettype wire

// ==== design/aud_recorder.sv ====
`timescale 1ns/1ps
`default_nettype none

module aud_recorder (
	input  wire                      i_AUD_BCLK,
	input  wire                      i_rst_n,
	input  wire aud_pkg::aud_mode_e  i_mode,
	input  wire                      i_adclrck,
	input  wire                      i_adcdat,
	input  wire                      i_gnt,
	output logic                     o_req,
	output aud_pkg::sram_req_t       o_sram,
	output logic [aud_pkg::ADDR_W:0] o_rec_len,
	output logic                     o_done
);
	import aud_pkg::*;

	aud_mode_e                   mode_d;
	logic                        lrck_d;
	logic                        lrck_fall;
	logic                        restart;
	logic                        shifting;
	logic [$clog2(SAMPLE_W)-1:0] bit_cnt;
	logic [SAMPLE_W-1:0]         shift_r;
	// one bit wider than the address so a full memory still counts
	logic [ADDR_W:0]             wr_cnt;

	assign lrck_fall = lrck_d & ~i_adclrck;
	assign restart   = (i_mode == MODE_RECD) && (mode_d == MODE_STOP);

	always_ff @(posedge i_AUD_BCLK or posedge i_rst_n) begin
		if (i_rst_n) begin
			mode_d   <= MODE_STOP;
			lrck_d   <= 1'b0;
			shifting <= 1'b0;
			bit_cnt  <= '0;
			o_req    <= 1'b0;
			o_done   <= 1'b0;
			wr_cnt   <= '0;
		end else begin
			mode_d <= i_mode;
			lrck_d <= i_adclrck;
			o_done <= 1'b0;
			// MSB arrives one edge after the fall
			if (i_mode != MODE_RECD) begin
				shifting <= 1'b0;
			end else if (lrck_fall && !wr_cnt[ADDR_W]) begin
				shifting <= 1'b1;
				bit_cnt  <= '0;
			end else if (shifting) begin
				bit_cnt <= bit_cnt + 1'b1;
				if (bit_cnt == ($clog2(SAMPLE_W))'(SAMPLE_W - 1)) begin
					shifting <= 1'b0;
					o_req    <= 1'b1;
				end
			end
			if (restart) begin
				wr_cnt <= '0;
			end else if (o_req && i_gnt) begin
				o_req  <= 1'b0;
				wr_cnt <= wr_cnt + 1'b1;
				if (wr_cnt[ADDR_W-1:0] == MEM_LAST)
					o_done <= 1'b1;
			end
		end
	end

	// word holds still until the next frame starts shifting
	always_ff @(posedge i_AUD_BCLK) begin
		if (shifting)
			shift_r <= {shift_r[SAMPLE_W-2:0], i_adcdat};
	end

	always_comb begin
		o_sram.addr  = wr_cnt[ADDR_W-1:0];
		o_sram.we    = o_req;
		o_sram.wdata = shift_r;
	end

	assign o_rec_len = wr_cnt;

	a_req_held: assert property (@(posedge i_AUD_BCLK) disable iff (i_rst_n)
		o_req && !i_gnt |=> o_req && $stable(o_sram));

endmodule

`default_nettype wire

// ==== design/aud_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module aud_top (
	input  wire                         i_AUD_BCLK,
	input  wire                         i_rst_n,
	input  wire                         i_key_rec,
	input  wire                         i_key_play,
	input  wire                         i_key_stop,
	input  wire aud_pkg::speed_cfg_t    i_speed,
	input  wire                         i_AUD_ADCLRCK,
	input  wire                         i_AUD_ADCDAT,
	input  wire                         i_AUD_DACLRCK,
	input  wire [aud_pkg::SAMPLE_W-1:0] i_sram_rdata,
	output logic                        o_AUD_DACDAT,
	output aud_pkg::sram_req_t          o_sram,
	output aud_pkg::aud_mode_e          o_mode
);
	import aud_pkg::*;

	logic                rec_req;
	logic                rec_gnt;
	logic                rec_done;
	sram_req_t           rec_sram;
	logic [ADDR_W:0]     rec_len;
	logic                dsp_req;
	logic                dsp_gnt;
	logic                dsp_done;
	sram_req_t           dsp_sram;
	logic [SAMPLE_W-1:0] dsp_sample;
	logic                dsp_valid;

	aud_ctrl u_ctrl (
		.i_AUD_BCLK (i_AUD_BCLK),
		.i_rst_n    (i_rst_n),
		.i_key_rec  (i_key_rec),
		.i_key_play (i_key_play),
		.i_key_stop (i_key_stop),
		.i_rec_done (rec_done),
		.i_play_done(dsp_done),
		.o_mode     (o_mode)
	);

	aud_recorder u_recorder (
		.i_AUD_BCLK(i_AUD_BCLK),
		.i_rst_n   (i_rst_n),
		.i_mode    (o_mode),
		.i_adclrck (i_AUD_ADCLRCK),
		.i_adcdat  (i_AUD_ADCDAT),
		.i_gnt     (rec_gnt),
		.o_req     (rec_req),
		.o_sram    (rec_sram),
		.o_rec_len (rec_len),
		.o_done    (rec_done)
	);

	aud_dsp u_dsp (
		.i_AUD_BCLK(i_AUD_BCLK),
		.i_rst_n   (i_rst_n),
		.i_mode    (o_mode),
		.i_speed   (i_speed),
		.i_rec_len (rec_len),
		.i_daclrck (i_AUD_DACLRCK),
		.i_gnt     (dsp_gnt),
		.i_rdata   (i_sram_rdata),
		.o_req     (dsp_req),
		.o_sram    (dsp_sram),
		.o_sample  (dsp_sample),
		.o_valid   (dsp_valid),
		.o_done    (dsp_done)
	);

	sram_arbiter u_arbiter (
		.i_AUD_BCLK(i_AUD_BCLK),
		.i_rst_n   (i_rst_n),
		.i_rec_req (rec_req),
		.i_rec_sram(rec_sram),
		.i_dsp_req (dsp_req),
		.i_dsp_sram(dsp_sram),
		.o_rec_gnt (rec_gnt),
		.o_dsp_gnt (dsp_gnt),
		.o_sram    (o_sram)
	);

	aud_player u_player (
		.i_AUD_BCLK(i_AUD_BCLK),
		.i_rst_n   (i_rst_n),
		.i_daclrck (i_AUD_DACLRCK),
		.i_sample  (dsp_sample),
		.i_valid   (dsp_valid),
		.o_dacdat  (o_AUD_DACDAT)
	);

endmodule

`default_nettype wire

// ==== design/sram_arbiter.sv ====
`timescale 1ns/1ps
`default_nettype none

module sram_arbiter (
	input  wire                     i_AUD_BCLK,
	input  wire                     i_rst_n,
	input  wire                     i_rec_req,
	input  wire aud_pkg::sram_req_t i_rec_sram,
	input  wire                     i_dsp_req,
	input  wire aud_pkg::sram_req_t i_dsp_sram,
	output logic                    o_rec_gnt,
	output logic                    o_dsp_gnt,
	output aud_pkg::sram_req_t      o_sram
);
	import aud_pkg::*;

	logic [4:0] dsp_wait;

	// recorder always wins
	assign o_rec_gnt = i_rec_req;
	assign o_dsp_gnt = i_dsp_req & ~i_rec_req;

	always_comb begin
		o_sram = o_rec_gnt ? i_rec_sram : i_dsp_sram;
		if (!o_rec_gnt && !o_dsp_gnt)
			o_sram.we = 1'b0;
	end

	// cycles the rate stage has been held off, saturating
	always_ff @(posedge i_AUD_BCLK or posedge i_rst_n) begin
		if (i_rst_n) begin
			dsp_wait <= '0;
		end else if (i_dsp_req && !o_dsp_gnt) begin
			if (dsp_wait != '1)
				dsp_wait <= dsp_wait + 1'b1;
		end else begin
			dsp_wait <= '0;
		end
	end

	a_dsp_wait: assert property (@(posedge i_AUD_BCLK) disable iff (i_rst_n)
		dsp_wait <= 5'd16);

	a_one_gnt: assert property (@(posedge i_AUD_BCLK) disable iff (i_rst_n)
		!(o_rec_gnt && o_dsp_gnt));

endmodule

`default_nettype wire

// ==== sim/tb_aud_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_aud_top;
	import aud_pkg::*;

	// frames per test with room for key presses and the DAC drain
	localparam int TEST_FRAMES = 80 + 70 + 30 + 130 + 80 + 1030;
	localparam int CYCLE_LIMIT = 64 * TEST_FRAMES * 5 / 4;
	localparam int MEM_WORDS   = 1 << ADDR_W;
	localparam logic [2:0] KEY_REC  = 3'b001;
	localparam logic [2:0] KEY_PLAY = 3'b010;
	localparam logic [2:0] KEY_STOP = 3'b100;
	localparam speed_cfg_t SPD_NORMAL = '{fast: 1'b0, slow: 1'b0, rate: 3'd0};
	localparam speed_cfg_t SPD_FAST   = '{fast: 1'b1, slow: 1'b0, rate: 3'd2};
	localparam speed_cfg_t SPD_SLOW   = '{fast: 1'b0, slow: 1'b1, rate: 3'd1};

	logic                clk;
	logic                rst_n;
	logic                key_rec;
	logic                key_play;
	logic                key_stop;
	speed_cfg_t          speed;
	logic                lrck;
	logic                adcdat;
	logic                dacdat;
	logic [SAMPLE_W-1:0] sram_rdata;
	sram_req_t           sram;
	aud_mode_e           mode;
	logic [SAMPLE_W-1:0] mem [MEM_WORDS];
	logic [SAMPLE_W-1:0] exp_mem [MEM_WORDS];
	logic [SAMPLE_W-1:0] exp_play [$];
	logic [SAMPLE_W-1:0] cur_sample;
	logic [SAMPLE_W-1:0] dac_word;
	logic [31:0]         rng;
	int                  phase;
	int                  exp_len;
	int                  played;
	int                  errors;
	int                  checks;
	int                  cycles;
	bit                  rec_on;
	bit                  started;

	tb_clkgen u_clkgen (.o_clk(clk), .o_rst_n(rst_n));

	aud_top DUT (
		.i_AUD_BCLK   (clk),
		.i_rst_n      (rst_n),
		.i_key_rec    (key_rec),
		.i_key_play   (key_play),
		.i_key_stop   (key_stop),
		.i_speed      (speed),
		.i_AUD_ADCLRCK(lrck),
		.i_AUD_ADCDAT (adcdat),
		.i_AUD_DACLRCK(lrck),
		.i_sram_rdata (sram_rdata),
		.o_AUD_DACDAT (dacdat),
		.o_sram       (sram),
		.o_mode       (mode)
	);

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		return y ^ (y << 5);
	endfunction

	// sample index played as word k
	function automatic int expected_index(input int k, input speed_cfg_t spd);
		if (spd.fast)
			return k * (int'(spd.rate) + 1);
		if (spd.slow)
			return k / (int'(spd.rate) + 1);
		return k;
	endfunction

	task automatic check_sample(input string name, input logic [SAMPLE_W-1:0] act,
		input logic [SAMPLE_W-1:0] exp);
		checks++;
		if (act !== exp) begin
			errors++;
			$display("Fail %0t %s expected %h actual %h", $time, name, exp, act);
		end
	endtask

	task automatic check_mode(input string name, input aud_mode_e act, input aud_mode_e exp);
		checks++;
		if (act !== exp) begin
			errors++;
			$display("Fail %0t %s expected %s actual %s", $time, name, exp.name(), act.name());
		end
	endtask

	task automatic check_addr(input string name, input logic [ADDR_W-1:0] act,
		input logic [ADDR_W-1:0] exp);
		checks++;
		if (act !== exp) begin
			errors++;
			$display("Fail %0t %s expected %0d actual %0d", $time, name, exp, act);
		end
	endtask

	task automatic check_count(input string name, input int act, input int exp);
		checks++;
		if (act != exp) begin
			errors++;
			$display("Fail %0t %s expected %0d actual %0d", $time, name, exp, act);
		end
	endtask

	task automatic wait_phase(input int p);
		@(posedge clk);
		while (phase != p)
			@(posedge clk);
	endtask

	task automatic wait_frames(input int n);
		repeat (n) wait_phase(0);
	endtask

	// key low for four cycles in the right half of a frame
	task automatic press_key(input logic [2:0] keys);
		wait_phase(39);
		{key_stop, key_play, key_rec} <= ~keys;
		repeat (4) @(posedge clk);
		{key_stop, key_play, key_rec} <= 3'b111;
	endtask

	task automatic play_and_check(input speed_cfg_t spd, input int pause_at);
		int k;
		int held;
		started = 1'b0;
		exp_play.delete();
		k = 0;
		while (expected_index(k, spd) < exp_len) begin
			exp_play.push_back(exp_mem[ADDR_W'(expected_index(k, spd))]);
			k++;
		end
		played = 0;
		@(posedge clk);
		speed <= spd;
		press_key(KEY_PLAY);
		@(negedge clk);
		check_mode("o_mode", mode, MODE_PLAY);
		if (pause_at > 0) begin
			while (played < pause_at)
				@(posedge clk);
			press_key(KEY_PLAY);
			@(negedge clk);
			check_mode("o_mode", mode, MODE_PLAY_PAUSE);
			// the word fetched before the pause still plays
			wait_frames(2);
			held = played;
			// silence is allowed again until the first word after the resume
			started = 1'b0;
			wait_frames(6);
			check_count("words played in pause", played, held);
			press_key(KEY_PLAY);
		end
		while (mode != MODE_STOP)
			@(negedge clk);
		wait_frames(2);
		check_count("words left to play", exp_play.size(), 0);
	endtask

	// one LRCK for ADC and DAC with the left channel in the low half
	always @(posedge clk) begin
		int nph;
		nph = (phase + 1) % 64;
		phase <= nph;
		lrck  <= (nph >= 32);
		if (nph == 0) begin
			rng = xorshift(rng);
			cur_sample = (rng[SAMPLE_W-1:0] == '0) ? 16'h0001 : rng[SAMPLE_W-1:0];
			if (rec_on && exp_len < MEM_WORDS) begin
				exp_mem[ADDR_W'(exp_len)] = cur_sample;
				exp_len++;
			end
		end
		adcdat <= (nph >= 1 && nph <= 16) ? cur_sample[4'(16 - nph)] : 1'b0;
	end

	// SRAM model writes on the clock and reads straight from the address
	assign sram_rdata = mem[sram.addr];

	always @(posedge clk) begin
		if (sram.we) begin
			mem[sram.addr] <= sram.wdata;
			check_addr("o_sram.addr", sram.addr, ADDR_W'(exp_len - 1));
			check_sample("o_sram.wdata", sram.wdata, exp_mem[ADDR_W'(exp_len - 1)]);
		end
	end

	// DAC monitor skips the silence before the first word of a run
	always @(negedge clk) begin
		if (phase >= 2 && phase <= 17)
			dac_word = {dac_word[SAMPLE_W-2:0], dacdat};
		if (phase == 17) begin
			if (dac_word != '0) begin
				started = 1'b1;
				if (exp_play.size() == 0) begin
					errors++;
					$display("unexpected sample %h on the DAC at %0t", dac_word, $time);
				end else begin
					check_sample("o_AUD_DACDAT", dac_word, exp_play.pop_front());
				end
				played++;
			end else if (started && exp_play.size() != 0) begin
				errors++;
				$display("silent frame on the DAC at %0t with %0d words still due",
					$time, exp_play.size());
			end
		end
	end

	initial begin
		cycles = 0;
		while (cycles < CYCLE_LIMIT) begin
			@(posedge clk);
			cycles++;
		end
		$display("timeout after %0d cycles, the run did not finish", CYCLE_LIMIT);
		$display("test failed");
		$finish;
	end

	initial begin
		{key_stop, key_play, key_rec} = 3'b111;
		speed      = SPD_NORMAL;
		lrck       = 1'b0;
		adcdat     = 1'b0;
		phase      = 0;
		rng        = 32'd50824;
		cur_sample = '0;
		dac_word   = '0;
		exp_len    = 0;
		played     = 0;
		errors     = 0;
		checks     = 0;
		rec_on     = 1'b0;
		started    = 1'b0;
		@(negedge rst_n);
		wait_frames(2);
		// record 40, pause 10, resume for 20 more, then stop
		press_key(KEY_REC);
		exp_len = 0;
		rec_on  = 1'b1;
		@(negedge clk);
		check_mode("o_mode", mode, MODE_RECD);
		while (exp_len < 40)
			@(posedge clk);
		press_key(KEY_REC);
		rec_on = 1'b0;
		@(negedge clk);
		check_mode("o_mode", mode, MODE_RECD_PAUSE);
		wait_frames(10);
		press_key(KEY_REC);
		rec_on = 1'b1;
		while (exp_len < 60)
			@(posedge clk);
		press_key(KEY_REC);
		rec_on = 1'b0;
		press_key(KEY_STOP);
		@(negedge clk);
		check_mode("o_mode", mode, MODE_STOP);
		check_count("rec_len", int'(DUT.rec_len), 60);
		for (int i = 0; i < 60; i++)
			check_sample("sram word", mem[ADDR_W'(i)], exp_mem[ADDR_W'(i)]);
		play_and_check(SPD_NORMAL, 0);
		play_and_check(SPD_FAST, 0);
		play_and_check(SPD_SLOW, 0);
		play_and_check(SPD_NORMAL, 15);
		// fill the whole memory without a stop press
		press_key(KEY_REC);
		exp_len = 0;
		rec_on  = 1'b1;
		while (mode != MODE_STOP)
			@(negedge clk);
		rec_on = 1'b0;
		check_count("rec_len", int'(DUT.rec_len), MEM_WORDS);
		for (int i = 0; i < MEM_WORDS; i++)
			check_sample("sram word", mem[ADDR_W'(i)], exp_mem[ADDR_W'(i)]);
		$display("%0d errors in %0d checks", errors, checks);
		if (errors == 0)
			$display("test passed");
		else
			$display("test failed");
		$finish;
	end

endmodule

`default_nettype wire

// ==== sim/tb_clkgen.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_clkgen (
	output logic o_clk,
	output logic o_rst_n
);
	// 8 ns bit clock
	initial begin
		o_clk = 1'b0;
		forever #4 o_clk = ~o_clk;
	end

	// active high reset, released after 10 cycles
	initial begin
		o_rst_n = 1'b1;
		repeat (10) @(posedge o_clk);
		o_rst_n <= 1'b0;
	end

endmodule

`default_nettype wire
